//--- hdl/rasCfgPkg.sv
package rasCfgPkg;

    // ******************************
    // Stack geometry
    // ******************************

    // One instruction address word
    localparam int addrW = 32;

    // Entries per stack
    localparam int stackDepth = 16;
    localparam int ptrW = 4;

    // Recursion counter per entry
    localparam int countW = 3;
    localparam logic [countW-1:0] countMax = countW'(7);

    // One entry is address over counter, counter in the low bits
    localparam int entryW = addrW + countW;

    // Whole committed image, entry 0 at the low end
    localparam int imageW = stackDepth * entryW;

endpackage

//--- hdl/rasOpPkg.sv
package rasOpPkg;

    // ******************************
    // BTB branch types
    // ******************************

    localparam logic [2:0] predNone = 3'd0;
    localparam logic [2:0] predCond = 3'd1;
    localparam logic [2:0] predJump = 3'd2;

    // Only these two touch the stack
    localparam logic [2:0] predCall = 3'd3;
    localparam logic [2:0] predReturn = 3'd4;

    // ******************************
    // Pre-decode stack operations
    // ******************************

    localparam logic [1:0] ptrHold = 2'd0;
    localparam logic [1:0] ptrPop = 2'd1;
    localparam logic [1:0] ptrPush = 2'd2;

    // Return address is packet address plus offset plus one instruction
    localparam int unsigned callStep = 4;

endpackage

//--- hdl/rasPredictDecode.sv
`timescale 1ns/1ps

module rasPredictDecode (
    // From BTB
    input  logic                          BtbAble,
    input  logic [2:0]                    BtbPredictType,
    input  logic [rasCfgPkg::addrW-1:0]   BtbPcDate,
    input  logic [3:0]                    BtbPcOffset,
    // Pre-decode correction
    input  logic                          UpAble,
    input  logic [1:0]                    UpPtrType,
    input  logic [rasCfgPkg::addrW-1:0]   UpAddrDate,
    // To speculative stack
    output logic                          specPush,
    output logic                          specPop,
    output logic [rasCfgPkg::addrW-1:0]   specData,
    output logic                          predValid
);

    import rasCfgPkg::*;
    import rasOpPkg::*;

    logic [addrW-1:0] callAddr;
    logic             btbCall;
    logic             btbReturn;

    // Fall-through of the call, wraps modulo 2^32
    assign callAddr = BtbPcDate + addrW'(BtbPcOffset) + addrW'(callStep);

    assign btbCall = (BtbPredictType == predCall);
    assign btbReturn = (BtbPredictType == predReturn);

    // Correction wins over the BTB in the same cycle
    always_comb begin
        specPush = 1'b0;
        specPop = 1'b0;
        specData = callAddr;
        if (UpAble) begin
            specData = UpAddrDate;
            specPush = (UpPtrType == ptrPush);
            specPop = (UpPtrType == ptrPop);
        end else if (BtbAble) begin
            specPush = btbCall;
            specPop = btbReturn;
        end
    end

    assign predValid = BtbAble;

endmodule

//--- hdl/rasCommitStack.sv
`timescale 1ns/1ps

module rasCommitStack (
    input  logic                          Clk,
    input  logic                          arstN,
    // From retire
    input  logic                          UpdateInAble,
    input  logic                          UpdateCall,
    input  logic                          UpdateReturn,
    input  logic [rasCfgPkg::addrW-1:0]   UpdateInDate,
    // Committed image for reload
    output logic [rasCfgPkg::ptrW-1:0]    commitPtr,
    output logic [rasCfgPkg::imageW-1:0]  commitImage
);

    import rasCfgPkg::*;

    logic [addrW-1:0]  addrMem [stackDepth];
    logic [countW-1:0] countMem [stackDepth];
    logic [ptrW-1:0]   topPtr;
    logic [ptrW-1:0]   nextPtr;
    logic [ptrW-1:0]   prevPtr;
    logic              doPush;
    logic              doPop;
    logic              topHit;

    // Call and return together cancel out
    assign doPush = UpdateInAble & UpdateCall & ~UpdateReturn;
    assign doPop = UpdateInAble & UpdateReturn & ~UpdateCall;

    // Circular pointer, no empty or full
    assign nextPtr = topPtr + ptrW'(1);
    assign prevPtr = topPtr - ptrW'(1);

    // Same target on top with room left in its counter
    assign topHit = (addrMem[topPtr] == UpdateInDate) && (countMem[topPtr] < countMax);

    // ******************************
    // Stack update
    // ******************************

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            topPtr <= '0;
            for (int i = 0; i < stackDepth; i++) begin
                addrMem[i] <= '0;
                countMem[i] <= '0;
            end
        end else if (doPush) begin
            if (topHit) begin
                countMem[topPtr] <= countMem[topPtr] + countW'(1);
            end else begin
                topPtr <= nextPtr;
                addrMem[nextPtr] <= UpdateInDate;
                countMem[nextPtr] <= '0;
            end
        end else if (doPop) begin
            if (countMem[topPtr] != '0) begin
                countMem[topPtr] <= countMem[topPtr] - countW'(1);
            end else begin
                topPtr <= prevPtr;
            end
        end
    end

    // ******************************
    // Image out
    // ******************************

    assign commitPtr = topPtr;

    for (genvar g = 0; g < stackDepth; g++) begin : gFlatten
        assign commitImage[g*entryW +: entryW] = {addrMem[g], countMem[g]};
    end

endmodule

//--- hdl/rasSpecStack.sv
`timescale 1ns/1ps

module rasSpecStack (
    input  logic                          Clk,
    input  logic                          arstN,
    input  logic                          RasStop,
    // From decoder
    input  logic                          specPush,
    input  logic                          specPop,
    input  logic [rasCfgPkg::addrW-1:0]   specData,
    input  logic                          predValid,
    // Redirect from retire
    input  logic                          UpdateReload,
    input  logic [rasCfgPkg::ptrW-1:0]    commitPtr,
    input  logic [rasCfgPkg::imageW-1:0]  commitImage,
    // Prediction toward FTQ
    output logic                          ToPreAble,
    output logic [rasCfgPkg::addrW-1:0]   ToPreAddr
);

    import rasCfgPkg::*;

    logic [addrW-1:0]  addrMem [stackDepth];
    logic [countW-1:0] countMem [stackDepth];
    logic [addrW-1:0]  reloadAddr [stackDepth];
    logic [countW-1:0] reloadCount [stackDepth];
    logic [ptrW-1:0]   topPtr;
    logic [ptrW-1:0]   nextPtr;
    logic [ptrW-1:0]   prevPtr;
    logic              topHit;

    // Split committed image back into entries
    for (genvar g = 0; g < stackDepth; g++) begin : gUnpack
        assign reloadAddr[g] = commitImage[g*entryW+countW +: addrW];
        assign reloadCount[g] = commitImage[g*entryW +: countW];
    end

    assign nextPtr = topPtr + ptrW'(1);
    assign prevPtr = topPtr - ptrW'(1);

    assign topHit = (addrMem[topPtr] == specData) && (countMem[topPtr] < countMax);

    // ******************************
    // Speculative stack
    // ******************************

    // Reload first, then stop, then decoder request
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            topPtr <= '0;
            for (int i = 0; i < stackDepth; i++) begin
                addrMem[i] <= '0;
                countMem[i] <= '0;
            end
        end else if (UpdateReload) begin
            topPtr <= commitPtr;
            for (int i = 0; i < stackDepth; i++) begin
                addrMem[i] <= reloadAddr[i];
                countMem[i] <= reloadCount[i];
            end
        end else if (!RasStop) begin
            if (specPush) begin
                if (topHit) begin
                    countMem[topPtr] <= countMem[topPtr] + countW'(1);
                end else begin
                    topPtr <= nextPtr;
                    addrMem[nextPtr] <= specData;
                    countMem[nextPtr] <= '0;
                end
            end else if (specPop) begin
                if (countMem[topPtr] != '0) begin
                    countMem[topPtr] <= countMem[topPtr] - countW'(1);
                end else begin
                    topPtr <= prevPtr;
                end
            end
        end
    end

    // ******************************
    // Prediction register
    // ******************************

    // Top as it was before this edge, so one cycle after the BTB
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            ToPreAble <= 1'b0;
            ToPreAddr <= '0;
        end else if (!RasStop) begin
            ToPreAble <= predValid;
            ToPreAddr <= addrMem[topPtr];
        end
    end

endmodule

//--- hdl/returnAddrStack.sv
`timescale 1ns/1ps

module returnAddrStack (
    input  logic                          Clk,
    input  logic                          arstN,
    input  logic                          RasStop,
    // From BTB
    input  logic                          BtbAble,
    input  logic [2:0]                    BtbPredictType,
    input  logic [rasCfgPkg::addrW-1:0]   BtbPcDate,
    input  logic [3:0]                    BtbPcOffset,
    // Pre-decode correction
    input  logic                          UpAble,
    input  logic [1:0]                    UpPtrType,
    input  logic [rasCfgPkg::addrW-1:0]   UpAddrDate,
    // To FTQ
    output logic                          ToPreAble,
    output logic [rasCfgPkg::addrW-1:0]   ToPreAddr,
    // From retire
    input  logic                          UpdateInAble,
    input  logic                          UpdateReload,
    input  logic [rasCfgPkg::addrW-1:0]   UpdateInDate,
    input  logic                          UpdateCall,
    input  logic                          UpdateReturn
);

    import rasCfgPkg::*;

    logic              specPush;
    logic              specPop;
    logic [addrW-1:0]  specData;
    logic              predValid;
    logic [ptrW-1:0]   commitPtr;
    logic [imageW-1:0] commitImage;

    rasPredictDecode uDecode (
        .BtbAble        (BtbAble),
        .BtbPredictType (BtbPredictType),
        .BtbPcDate      (BtbPcDate),
        .BtbPcOffset    (BtbPcOffset),
        .UpAble         (UpAble),
        .UpPtrType      (UpPtrType),
        .UpAddrDate     (UpAddrDate),
        .specPush       (specPush),
        .specPop        (specPop),
        .specData       (specData),
        .predValid      (predValid)
    );

    rasCommitStack uCommit (
        .Clk          (Clk),
        .arstN        (arstN),
        .UpdateInAble (UpdateInAble),
        .UpdateCall   (UpdateCall),
        .UpdateReturn (UpdateReturn),
        .UpdateInDate (UpdateInDate),
        .commitPtr    (commitPtr),
        .commitImage  (commitImage)
    );

    rasSpecStack uSpec (
        .Clk          (Clk),
        .arstN        (arstN),
        .RasStop      (RasStop),
        .specPush     (specPush),
        .specPop      (specPop),
        .specData     (specData),
        .predValid    (predValid),
        .UpdateReload (UpdateReload),
        .commitPtr    (commitPtr),
        .commitImage  (commitImage),
        .ToPreAble    (ToPreAble),
        .ToPreAddr    (ToPreAddr)
    );

endmodule

//--- tests/returnAddrStack_assertions.sv
`timescale 1ns/1ps

module returnAddrStackAssertions (
    input  logic                          Clk,
    input  logic                          arstN,
    input  logic                          RasStop,
    input  logic                          UpdateReload,
    input  logic                          ToPreAble,
    input  logic [rasCfgPkg::addrW-1:0]   ToPreAddr,
    input  logic [rasCfgPkg::ptrW-1:0]    topPtr
);

    import rasCfgPkg::*;

    int failCount = 0;

    // Quiet in reset and on the first edge out of it
    resetQuiet: assert property (@(posedge Clk) (!arstN || $rose(arstN)) |-> !ToPreAble)
        else begin
            $error("ToPreAble high during or right after reset");
            failCount++;
        end

    stopHolds: assert property (@(posedge Clk) disable iff (!arstN)
        RasStop |=> $stable(ToPreAble) && $stable(ToPreAddr))
        else begin
            $error("prediction outputs changed while RasStop was high");
            failCount++;
        end

    // Single step per cycle unless reloading
    ptrStep: assert property (@(posedge Clk) disable iff (!arstN)
        !UpdateReload |=> (topPtr == $past(topPtr)) ||
            (topPtr == $past(topPtr) + ptrW'(1)) || (topPtr == $past(topPtr) - ptrW'(1)))
        else begin
            $error("speculative pointer jumped by more than one entry");
            failCount++;
        end

endmodule

bind rasSpecStack returnAddrStackAssertions uAssert (
    .Clk          (Clk),
    .arstN        (arstN),
    .RasStop      (RasStop),
    .UpdateReload (UpdateReload),
    .ToPreAble    (ToPreAble),
    .ToPreAddr    (ToPreAddr),
    .topPtr       (topPtr)
);

//--- tests/returnAddrStackTb.sv
`timescale 1ns/1ps

module returnAddrStackTb;

    import rasCfgPkg::*;
    import rasOpPkg::*;

    // Cycle budget per test, upper bounds
    localparam int callsCycles = 14;
    localparam int recursionCycles = 21;
    localparam int wrapCycles = 41;
    localparam int overrideCycles = 14;
    localparam int redirectCycles = 16;
    localparam int stopCycles = 8 * 7 + 1;
    localparam int runCycles = 8 + callsCycles + recursionCycles + wrapCycles
        + overrideCycles + redirectCycles + stopCycles + 2;

    logic              Clk = 1'b0;
    logic              arstN;
    logic              RasStop;
    logic              BtbAble;
    logic [2:0]        BtbPredictType;
    logic [addrW-1:0]  BtbPcDate;
    logic [3:0]        BtbPcOffset;
    logic              UpAble;
    logic [1:0]        UpPtrType;
    logic [addrW-1:0]  UpAddrDate;
    logic              UpdateInAble;
    logic              UpdateReload;
    logic [addrW-1:0]  UpdateInDate;
    logic              UpdateCall;
    logic              UpdateReturn;
    logic              ToPreAble;
    logic [addrW-1:0]  ToPreAddr;

    // Model state, index 0 speculative, 1 committed
    logic [addrW-1:0]  modelAddr [2][stackDepth];
    logic [countW-1:0] modelCount [2][stackDepth];
    logic [ptrW-1:0]   modelTop [2];
    logic              expAble;
    logic [addrW-1:0]  expAddr;
    string             testName;

    returnAddrStack UUT (.*);

    always #50 Clk = ~Clk;

    // ******************************
    // Reference model
    // ******************************

    function automatic void resetModel();
        for (int s = 0; s < 2; s++) begin
            modelTop[s] = '0;
            for (int i = 0; i < stackDepth; i++) begin
                modelAddr[s][i] = '0;
                modelCount[s][i] = '0;
            end
        end
        expAble = 1'b0;
        expAddr = '0;
    endfunction

    function automatic void stackOp(int s, logic push, logic pop, logic [addrW-1:0] data);
        logic [ptrW-1:0] top;
        top = modelTop[s];
        if (push) begin
            if (modelAddr[s][top] == data && modelCount[s][top] < countMax) begin
                modelCount[s][top] = modelCount[s][top] + 1'b1;
            end else begin
                top = top + 1'b1;
                modelTop[s] = top;
                modelAddr[s][top] = data;
                modelCount[s][top] = '0;
            end
        end else if (pop) begin
            if (modelCount[s][top] != '0) begin
                modelCount[s][top] = modelCount[s][top] - 1'b1;
            end else begin
                modelTop[s] = top - 1'b1;
            end
        end
    endfunction

    // One clock edge: expected outputs first, then both stacks
    function automatic void referenceStep();
        logic             push;
        logic             pop;
        logic [addrW-1:0] data;
        push = 1'b0;
        pop = 1'b0;
        data = '0;
        if (UpAble) begin
            push = (UpPtrType == ptrPush);
            pop = (UpPtrType == ptrPop);
            data = UpAddrDate;
        end else if (BtbAble) begin
            push = (BtbPredictType == predCall);
            pop = (BtbPredictType == predReturn);
            data = BtbPcDate + BtbPcOffset + callStep;
        end
        if (!RasStop) begin
            expAble = BtbAble;
            expAddr = modelAddr[0][modelTop[0]];
        end
        // Copy sees the committed stack before this edge's retire op
        if (UpdateReload) begin
            modelTop[0] = modelTop[1];
            for (int i = 0; i < stackDepth; i++) begin
                modelAddr[0][i] = modelAddr[1][i];
                modelCount[0][i] = modelCount[1][i];
            end
        end else if (!RasStop) begin
            stackOp(0, push, pop, data);
        end
        stackOp(1, UpdateInAble && UpdateCall && !UpdateReturn,
            UpdateInAble && UpdateReturn && !UpdateCall, UpdateInDate);
    endfunction

    task automatic checkValid(logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAIL %s ToPreAble expected %0b actual %0b", testName, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "ToPreAble mismatch");
        end
    endtask

    task automatic checkAddr(logic [addrW-1:0] expected, logic [addrW-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s ToPreAddr expected %h actual %h", testName, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "ToPreAddr mismatch");
        end
    endtask

    always begin
        @(posedge Clk);
        if (arstN === 1'b1) begin
            referenceStep();
            #1;
            checkValid(expAble, ToPreAble);
            if (expAble) begin
                checkAddr(expAddr, ToPreAddr);
            end
        end
    end

    // Bound checker failures
    initial begin
        wait (UUT.uSpec.uAssert.failCount != 0);
        $display("Assertion failure in the speculative stack checker");
        $display("ERRORS FOUND");
        $fatal(1, "assertion failed");
    end

    initial begin
        #((runCycles + 100) * 100);
        $display("Timeout: the tests did not finish within their cycle budget");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    // ******************************
    // Stimulus
    // ******************************

    task automatic tick();
        @(posedge Clk);
        #5;
    endtask

    task automatic clearInputs();
        RasStop = 1'b0;
        BtbAble = 1'b0;
        BtbPredictType = predNone;
        BtbPcDate = '0;
        BtbPcOffset = '0;
        UpAble = 1'b0;
        UpPtrType = ptrHold;
        UpAddrDate = '0;
        UpdateInAble = 1'b0;
        UpdateReload = 1'b0;
        UpdateInDate = '0;
        UpdateCall = 1'b0;
        UpdateReturn = 1'b0;
    endtask

    task automatic setBtb(logic [2:0] kind, logic [addrW-1:0] pc, logic [3:0] offset);
        BtbAble = 1'b1;
        BtbPredictType = kind;
        BtbPcDate = pc;
        BtbPcOffset = offset;
    endtask

    task automatic cycleBtb(logic [2:0] kind, logic [addrW-1:0] pc, logic [3:0] offset);
        clearInputs();
        setBtb(kind, pc, offset);
        tick();
    endtask

    initial begin
        int stopLen;
        void'($urandom(32'h455e));
        arstN = 1'b0;
        clearInputs();
        resetModel();
        testName = "reset";
        repeat (8) @(posedge Clk);
        #5;
        arstN = 1'b1;

        testName = "callsReturns";
        for (int i = 0; i < 6; i++) cycleBtb(predCall, $urandom, 4'($urandom));
        for (int i = 0; i < 7; i++) cycleBtb(predReturn, $urandom, 4'($urandom));
        cycleBtb(predNone, '0, '0);

        testName = "recursion";
        for (int i = 0; i < 9; i++) cycleBtb(predCall, 32'h0000_4000, 4'd4);
        for (int i = 0; i < 11; i++) cycleBtb(predReturn, 32'h0000_5000, 4'd0);
        cycleBtb(predNone, '0, '0);

        testName = "overflowWrap";
        for (int i = 0; i < 20; i++) cycleBtb(predCall, 32'h0010_0000 + i * 64, 4'(i));
        for (int i = 0; i < 20; i++) cycleBtb(predReturn, $urandom, 4'($urandom));
        cycleBtb(predNone, '0, '0);

        testName = "predecodeOverride";
        for (int i = 0; i < 7; i++) begin
            clearInputs();
            setBtb(predCall, $urandom, 4'($urandom));
            BtbAble = (i % 3 != 0);
            UpAble = 1'b1;
            UpPtrType = (i < 4) ? ptrPush : ((i < 6) ? ptrPop : ptrHold);
            UpAddrDate = $urandom;
            tick();
        end
        for (int i = 0; i < 6; i++) cycleBtb(predReturn, $urandom, 4'($urandom));

        testName = "retireRedirect";
        // Speculative calls diverge from the retired ones
        for (int i = 0; i < 4; i++) begin
            clearInputs();
            setBtb(predCall, 32'h0300_0000 + i * 32, 4'd0);
            UpdateInAble = 1'b1;
            UpdateCall = 1'b1;
            UpdateInDate = 32'h0200_0000 + i * 16;
            tick();
        end
        clearInputs();
        UpdateInAble = 1'b1;
        UpdateReturn = 1'b1;
        tick();
        clearInputs();
        setBtb(predReturn, '0, '0);
        UpdateReload = 1'b1;
        UpdateInAble = 1'b1;
        UpdateCall = 1'b1;
        UpdateInDate = 32'h0bad_f00c;
        tick();
        for (int i = 0; i < 4; i++) cycleBtb(predReturn, $urandom, 4'($urandom));
        // Second reload picks up the retire push of the first one
        clearInputs();
        UpdateReload = 1'b1;
        tick();
        for (int i = 0; i < 4; i++) cycleBtb(predReturn, $urandom, 4'($urandom));

        testName = "stop";
        for (int i = 0; i < 8; i++) begin
            stopLen = 1 + $urandom % 5;
            for (int k = 0; k < stopLen; k++) begin
                clearInputs();
                setBtb(($urandom % 2) ? predCall : predReturn, $urandom, 4'($urandom));
                RasStop = 1'b1;
                tick();
            end
            cycleBtb(predCall, $urandom, 4'($urandom));
            cycleBtb(predReturn, $urandom, 4'($urandom));
        end
        cycleBtb(predNone, '0, '0);

        clearInputs();
        tick();
        tick();
        if (UUT.uSpec.uAssert.failCount == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "assertion failures in the bound checker");
        end
    end

endmodule

//--- filelist.f
hdl/rasCfgPkg.sv
hdl/rasOpPkg.sv
hdl/rasPredictDecode.sv
hdl/rasCommitStack.sv
hdl/rasSpecStack.sv
hdl/returnAddrStack.sv
tests/returnAddrStack_assertions.sv
tests/returnAddrStackTb.sv
